//--- filelist.f
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_fetch_decode.sv
rtl/rv_execute.sv
rtl/rv_core.sv
testbench/tb_clock.sv
testbench/rv_core_tb.sv

//--- rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input rv_pkg::word_t i_a,
	input rv_pkg::word_t i_b,
	input rv_pkg::alu_op_e i_op,
	output rv_pkg::word_t o_result
);
	logic [4:0] shamt;

	assign shamt = i_b[4:0];  // Shifts use the low five bits only

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD: o_result = i_a + i_b;
			rv_pkg::ALU_SUB: o_result = i_a - i_b;
			rv_pkg::ALU_XOR: o_result = i_a ^ i_b;
			rv_pkg::ALU_OR: o_result = i_a | i_b;
			rv_pkg::ALU_AND: o_result = i_a & i_b;
			rv_pkg::ALU_SLL: o_result = i_a << shamt;
			rv_pkg::ALU_SRL: o_result = i_a >> shamt;
			rv_pkg::ALU_SRA: o_result = $signed(i_a) >>> shamt;
			rv_pkg::ALU_LT: o_result = {31'd0, $signed(i_a) < $signed(i_b)};
			rv_pkg::ALU_LTU: o_result = {31'd0, i_a < i_b};
			rv_pkg::ALU_EQ: o_result = {31'd0, i_a == i_b};
			default: o_result = '0;
		endcase
	end
endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
	parameter rv_pkg::word_t RESET_PC = '0
)(
	input logic clk,
	input logic reset,
	input rv_pkg::word_t i_imem_rddata,
	output rv_pkg::word_t o_imem_addr,
	output logic o_imem_rd,
	output rv_pkg::word_t o_st_addr,
	output rv_pkg::word_t o_st_data,
	output logic o_st_wr
);
	rv_pkg::dec_instr_t dec;
	rv_pkg::redirect_t redirect;
	rv_pkg::wb_t wb;
	rv_pkg::store_t store;
	rv_pkg::reg_idx_t rs1_idx;
	rv_pkg::reg_idx_t rs2_idx;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;

	rv_fetch_decode #(.RESET_PC(RESET_PC)) u_fetch_decode (
		.clk        (clk),
		.reset      (reset),
		.i_instr    (i_imem_rddata),
		.i_redirect (redirect),
		.o_pc       (o_imem_addr),
		.o_fetch_rd (o_imem_rd),
		.o_dec      (dec)
	);

	rv_execute u_execute (
		.clk        (clk),
		.reset      (reset),
		.i_dec      (dec),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.o_rs1_idx  (rs1_idx),
		.o_rs2_idx  (rs2_idx),
		.o_redirect (redirect),
		.o_wb       (wb),
		.o_store    (store)
	);

	rv_regfile u_regfile (
		.clk        (clk),
		.reset      (reset),
		.i_rs1_idx  (rs1_idx),
		.i_rs2_idx  (rs2_idx),
		.i_wb       (wb),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	// Store request onto the data port
	assign o_st_wr = store.valid;
	assign o_st_addr = store.addr;
	assign o_st_data = store.data;
endmodule

//--- rtl/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input logic clk,
	input logic reset,
	input rv_pkg::dec_instr_t i_dec,
	input rv_pkg::word_t i_rs1_data,
	input rv_pkg::word_t i_rs2_data,
	output rv_pkg::reg_idx_t o_rs1_idx,
	output rv_pkg::reg_idx_t o_rs2_idx,
	output rv_pkg::redirect_t o_redirect,
	output rv_pkg::wb_t o_wb,
	output rv_pkg::store_t o_store
);
	rv_pkg::word_t rs1_val;
	rv_pkg::word_t rs2_val;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_out;
	rv_pkg::word_t pc_imm;
	rv_pkg::word_t result;
	rv_pkg::alu_op_e alu_op;
	logic writes_rd;

	assign o_rs1_idx = i_dec.rs1;
	assign o_rs2_idx = i_dec.rs2;

	// Previous instruction's result is not in the register file yet
	assign rs1_val = (o_wb.valid && o_wb.rd != '0 && o_wb.rd == i_dec.rs1)
		? o_wb.data : i_rs1_data;
	assign rs2_val = (o_wb.valid && o_wb.rd != '0 && o_wb.rd == i_dec.rs2)
		? o_wb.data : i_rs2_data;

	assign op_b = (i_dec.opcode == rv_pkg::I || i_dec.opcode == rv_pkg::S
		|| i_dec.opcode == rv_pkg::JALR) ? i_dec.imm : rs2_val;

	always_comb begin
		case (i_dec.instr)
			rv_pkg::OP_SUB: alu_op = rv_pkg::ALU_SUB;
			rv_pkg::OP_XOR, rv_pkg::OP_XORI: alu_op = rv_pkg::ALU_XOR;
			rv_pkg::OP_OR, rv_pkg::OP_ORI: alu_op = rv_pkg::ALU_OR;
			rv_pkg::OP_AND, rv_pkg::OP_ANDI: alu_op = rv_pkg::ALU_AND;
			rv_pkg::OP_SLL, rv_pkg::OP_SLLI: alu_op = rv_pkg::ALU_SLL;
			rv_pkg::OP_SRL, rv_pkg::OP_SRLI: alu_op = rv_pkg::ALU_SRL;
			rv_pkg::OP_SRA, rv_pkg::OP_SRAI: alu_op = rv_pkg::ALU_SRA;
			rv_pkg::OP_SLT, rv_pkg::OP_SLTI,
			rv_pkg::OP_BLT, rv_pkg::OP_BGE: alu_op = rv_pkg::ALU_LT;
			rv_pkg::OP_SLTU, rv_pkg::OP_SLTIU,
			rv_pkg::OP_BLTU, rv_pkg::OP_BGEU: alu_op = rv_pkg::ALU_LTU;
			rv_pkg::OP_BEQ, rv_pkg::OP_BNE: alu_op = rv_pkg::ALU_EQ;
			default: alu_op = rv_pkg::ALU_ADD;  // Also SW address and JALR target
		endcase
	end

	rv_alu u_alu (
		.i_a      (rs1_val),
		.i_b      (op_b),
		.i_op     (alu_op),
		.o_result (alu_out)
	);

	assign pc_imm = i_dec.pc + i_dec.imm;

	always_comb begin
		case (i_dec.instr)
			rv_pkg::OP_LUI: result = i_dec.imm;
			rv_pkg::OP_AUIPC: result = pc_imm;
			rv_pkg::OP_JAL, rv_pkg::OP_JALR: result = i_dec.pc + 32'd4;  // Link
			rv_pkg::OP_BNE, rv_pkg::OP_BGE,
			rv_pkg::OP_BGEU: result = {31'd0, ~alu_out[0]};
			default: result = alu_out;
		endcase
	end

	// Branch taken when the compare result is set
	assign o_redirect.taken = i_dec.valid && (i_dec.opcode == rv_pkg::J
		|| i_dec.opcode == rv_pkg::JALR || (i_dec.opcode == rv_pkg::B && result[0]));
	assign o_redirect.target = (i_dec.opcode == rv_pkg::JALR)
		? {alu_out[31:1], 1'b0} : pc_imm;

	assign writes_rd = i_dec.opcode inside {rv_pkg::R, rv_pkg::I, rv_pkg::LUI,
		rv_pkg::AUIPC, rv_pkg::J, rv_pkg::JALR};

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb.valid <= 1'b0;
			o_store.valid <= 1'b0;
		end else begin
			o_wb.valid <= i_dec.valid & writes_rd;
			o_store.valid <= i_dec.valid && i_dec.instr == rv_pkg::OP_SW;
		end
		o_wb.rd <= i_dec.rd;
		o_wb.data <= result;
		o_store.addr <= alu_out;
		o_store.data <= rs2_val;  // Forwarded store data
	end
endmodule

//--- rtl/rv_fetch_decode.sv
`timescale 1ns/1ps

module rv_fetch_decode #(
	parameter rv_pkg::word_t RESET_PC = '0
)(
	input logic clk,
	input logic reset,
	input rv_pkg::word_t i_instr,           // Word for the address of the previous cycle
	input rv_pkg::redirect_t i_redirect,
	output rv_pkg::word_t o_pc,
	output logic o_fetch_rd,
	output rv_pkg::dec_instr_t o_dec
);
	rv_pkg::word_t pc;
	rv_pkg::word_t fetch_pc;    // PC of the word arriving now
	logic fetch_valid;
	rv_pkg::word_t word;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::dec_instr_t dec_next;

	assign o_pc = pc;
	assign o_fetch_rd = ~reset;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
			fetch_valid <= 1'b0;
		end else begin
			pc <= i_redirect.taken ? i_redirect.target : pc + 32'd4;
			fetch_valid <= ~i_redirect.taken;  // Word already in flight is stale
		end
		fetch_pc <= pc;
	end

	// Dead fetch slots enter the decoder as a bubble
	assign word = fetch_valid ? i_instr : rv_pkg::NOP_WORD;
	assign funct3 = word[14:12];
	assign funct7 = word[31:25];

	always_comb begin
		dec_next.pc = fetch_pc;
		dec_next.opcode = rv_pkg::opcode_e'(word[6:0]);
		dec_next.rs1 = '0;
		dec_next.rs2 = '0;
		dec_next.rd = '0;
		dec_next.imm = '0;
		dec_next.instr = rv_pkg::OP_NOP;

		case (dec_next.opcode)
			rv_pkg::R: begin
				dec_next.rs1 = word[19:15];
				dec_next.rs2 = word[24:20];
				dec_next.rd = word[11:7];
				case ({funct7, funct3})
					10'b0000000_000: dec_next.instr = rv_pkg::OP_ADD;
					10'b0100000_000: dec_next.instr = rv_pkg::OP_SUB;
					10'b0000000_100: dec_next.instr = rv_pkg::OP_XOR;
					10'b0000000_110: dec_next.instr = rv_pkg::OP_OR;
					10'b0000000_111: dec_next.instr = rv_pkg::OP_AND;
					10'b0000000_001: dec_next.instr = rv_pkg::OP_SLL;
					10'b0000000_101: dec_next.instr = rv_pkg::OP_SRL;
					10'b0100000_101: dec_next.instr = rv_pkg::OP_SRA;
					10'b0000000_010: dec_next.instr = rv_pkg::OP_SLT;
					10'b0000000_011: dec_next.instr = rv_pkg::OP_SLTU;
					default: dec_next.instr = rv_pkg::OP_NOP;
				endcase
			end
			rv_pkg::I, rv_pkg::JALR: begin
				dec_next.rs1 = word[19:15];
				dec_next.rd = word[11:7];
				dec_next.imm = {{20{word[31]}}, word[31:20]};
				if (dec_next.opcode == rv_pkg::JALR)
					dec_next.instr = (funct3 == 3'h0) ? rv_pkg::OP_JALR : rv_pkg::OP_NOP;
				else begin
					case (funct3)
						3'h0: dec_next.instr = rv_pkg::OP_ADDI;
						3'h4: dec_next.instr = rv_pkg::OP_XORI;
						3'h6: dec_next.instr = rv_pkg::OP_ORI;
						3'h7: dec_next.instr = rv_pkg::OP_ANDI;
						3'h2: dec_next.instr = rv_pkg::OP_SLTI;
						3'h3: dec_next.instr = rv_pkg::OP_SLTIU;
						3'h1: dec_next.instr = (funct7 == 7'h00) ? rv_pkg::OP_SLLI : rv_pkg::OP_NOP;
						default: begin  // funct7 picks logical or arithmetic
							if (funct7 == 7'h00)
								dec_next.instr = rv_pkg::OP_SRLI;
							else if (funct7 == 7'h20)
								dec_next.instr = rv_pkg::OP_SRAI;
						end
					endcase
				end
			end
			rv_pkg::S: begin
				dec_next.rs1 = word[19:15];
				dec_next.rs2 = word[24:20];
				dec_next.imm = {{20{word[31]}}, word[31:25], word[11:7]};
				dec_next.instr = (funct3 == 3'h2) ? rv_pkg::OP_SW : rv_pkg::OP_NOP;  // SW only
			end
			rv_pkg::B: begin
				dec_next.rs1 = word[19:15];
				dec_next.rs2 = word[24:20];
				dec_next.imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
				case (funct3)
					3'h0: dec_next.instr = rv_pkg::OP_BEQ;
					3'h1: dec_next.instr = rv_pkg::OP_BNE;
					3'h4: dec_next.instr = rv_pkg::OP_BLT;
					3'h5: dec_next.instr = rv_pkg::OP_BGE;
					3'h6: dec_next.instr = rv_pkg::OP_BLTU;
					3'h7: dec_next.instr = rv_pkg::OP_BGEU;
					default: dec_next.instr = rv_pkg::OP_NOP;
				endcase
			end
			rv_pkg::LUI, rv_pkg::AUIPC: begin
				dec_next.rd = word[11:7];
				dec_next.imm = {word[31:12], 12'd0};
				dec_next.instr = (dec_next.opcode == rv_pkg::LUI) ? rv_pkg::OP_LUI
					: rv_pkg::OP_AUIPC;
			end
			rv_pkg::J: begin
				dec_next.rd = word[11:7];
				dec_next.imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
				dec_next.instr = rv_pkg::OP_JAL;
			end
			default: dec_next.instr = rv_pkg::OP_NOP;  // Unknown opcode
		endcase

		dec_next.valid = (word != rv_pkg::NOP_WORD) && (dec_next.instr != rv_pkg::OP_NOP);
	end

	always_ff @(posedge clk) begin
		o_dec <= dec_next;
		if (reset || i_redirect.taken)
			o_dec.valid <= 1'b0;  // Squash the younger instruction
	end
endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;
	typedef logic [31:0] word_t;    // Data, address or instruction word
	typedef logic [4:0] reg_idx_t;  // Register index

	// RV32I major opcodes
	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		S     = 7'b0100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		B     = 7'b1100011,
		J     = 7'b1101111,
		JALR  = 7'b1100111
	} opcode_e;

	typedef enum logic [4:0] {
		OP_NOP,
		OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
		OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
		OP_ADDI, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
		OP_LUI, OP_AUIPC,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_JAL, OP_JALR,
		OP_SW
	} instr_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LT, ALU_LTU, ALU_EQ
	} alu_op_e;

	localparam word_t NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

	typedef struct packed {
		logic valid;
		word_t pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t imm;      // Sign-extended immediate
		instr_e instr;
		opcode_e opcode;
	} dec_instr_t;

	typedef struct packed {
		logic valid;
		reg_idx_t rd;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic valid;
		word_t addr;
		word_t data;
	} store_t;
endpackage

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input logic clk,
	input logic reset,
	input rv_pkg::reg_idx_t i_rs1_idx,
	input rv_pkg::reg_idx_t i_rs2_idx,
	input rv_pkg::wb_t i_wb,
	output rv_pkg::word_t o_rs1_data,
	output rv_pkg::word_t o_rs2_data
);
	rv_pkg::word_t regs [32];

	// x0 is never written, so it stays zero from reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_wb.valid && i_wb.rd != '0) begin
			regs[i_wb.rd] <= i_wb.data;
		end
	end

	// Reads see the old value on a same-cycle write
	assign o_rs1_data = regs[i_rs1_idx];
	assign o_rs2_data = regs[i_rs2_idx];
endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rv_core_tb -f filelist.f -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "Simulation ended without a verdict"
	exit 1
fi

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
	logic clk;
	logic reset = 1'b1;
	rv_pkg::word_t imem_rddata = '0;
	rv_pkg::word_t imem_addr;
	logic imem_rd;
	rv_pkg::word_t st_addr;
	rv_pkg::word_t st_data;
	logic st_wr;

	rv_pkg::word_t prog [$];      // Program ROM, indexed by address / 4
	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	string exp_name [$];
	int stores_seen = 0;
	logic tables_ready = 1'b0;

	tb_clock u_clock (.clk(clk));

	rv_core #(.RESET_PC(32'h0000_0000)) uut (
		.clk           (clk),
		.reset         (reset),
		.i_imem_rddata (imem_rddata),
		.o_imem_addr   (imem_addr),
		.o_imem_rd     (imem_rd),
		.o_st_addr     (st_addr),
		.o_st_data     (st_data),
		.o_st_wr       (st_wr)
	);

	// RV32I encoders with fields in instruction order
	function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic rv_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};  // OP-IMM or JALR
	endfunction

	function automatic rv_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};  // SW
	endfunction

	function automatic rv_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic rv_pkg::word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rv_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	// sw x1, 256(x0) is never on the executed path
	function automatic rv_pkg::word_t poison_store();
		return s_type(12'd256, 1, 0);
	endfunction

	function automatic rv_pkg::word_t rom_word(rv_pkg::word_t addr);
		int idx;
		idx = int'(addr >> 2);
		if (addr[1:0] != 2'b00)
			return poison_store();  // Misaligned fetch runs into stores
		if (idx < prog.size())
			return prog[idx];
		return j_type(21'd0, 0);  // Jump to self past the table
	endfunction

	// Not-taken branch, then a taken one over two stores
	task automatic push_branch_pair(logic [2:0] f3, logic [4:0] nt_rs1, logic [4:0] nt_rs2,
			logic [4:0] tk_rs1, logic [4:0] tk_rs2);
		prog.push_back(b_type(13'd8, nt_rs2, nt_rs1, f3));  // Wrongly taken hits a poison store
		prog.push_back(b_type(13'd12, tk_rs2, tk_rs1, f3));
		prog.push_back(poison_store());
		prog.push_back(poison_store());
	endtask

	task automatic load_program();
		prog.push_back(i_type(12'd12, 0, 3'd0, 1, 7'h13));        // addi x1, x0, 12
		prog.push_back(i_type(12'd5, 0, 3'd0, 2, 7'h13));         // addi x2, x0, 5
		prog.push_back(r_type(7'h00, 2, 1, 3'd0, 3));             // add x3, x1, x2
		prog.push_back(s_type(12'd0, 3, 0));
		prog.push_back(r_type(7'h20, 2, 1, 3'd0, 4));             // sub x4, x1, x2
		prog.push_back(s_type(12'd4, 4, 0));
		prog.push_back(r_type(7'h00, 2, 1, 3'd4, 5));             // xor
		prog.push_back(s_type(12'd8, 5, 0));
		prog.push_back(r_type(7'h00, 2, 1, 3'd6, 6));             // or
		prog.push_back(s_type(12'd12, 6, 0));
		prog.push_back(r_type(7'h00, 2, 1, 3'd7, 7));             // and
		prog.push_back(s_type(12'd16, 7, 0));
		prog.push_back(i_type(-12'd16, 0, 3'd0, 10, 7'h13));      // addi x10, x0, -16
		prog.push_back(r_type(7'h00, 1, 10, 3'd2, 11));           // slt x11, x10, x1
		prog.push_back(r_type(7'h00, 1, 10, 3'd3, 12));           // sltu x12, x10, x1
		prog.push_back(s_type(12'd20, 11, 0));
		prog.push_back(s_type(12'd24, 12, 0));
		prog.push_back(s_type(12'd28, 10, 0));
		prog.push_back(i_type({7'h00, 5'd4}, 10, 3'd1, 13, 7'h13)); // slli x13, x10, 4
		prog.push_back(i_type({7'h00, 5'd4}, 10, 3'd5, 14, 7'h13)); // srli x14, x10, 4
		prog.push_back(i_type({7'h20, 5'd2}, 10, 3'd5, 15, 7'h13)); // srai x15, x10, 2
		prog.push_back(i_type(-12'd15, 10, 3'd2, 16, 7'h13));     // slti x16, x10, -15
		prog.push_back(i_type(-12'd1, 1, 3'd3, 17, 7'h13));       // sltiu x17, x1, -1
		prog.push_back(s_type(12'd32, 13, 0));
		prog.push_back(s_type(12'd36, 14, 0));
		prog.push_back(s_type(12'd40, 15, 0));
		prog.push_back(s_type(12'd44, 16, 0));
		prog.push_back(s_type(12'd48, 17, 0));
		// Each instruction needs the result just before it
		prog.push_back(i_type(12'd1, 1, 3'd0, 18, 7'h13));        // addi x18, x1, 1
		prog.push_back(r_type(7'h00, 18, 18, 3'd0, 18));          // add x18, x18, x18
		prog.push_back(r_type(7'h20, 2, 18, 3'd0, 18));           // sub x18, x18, x2
		prog.push_back(s_type(12'd52, 18, 0));
		prog.push_back(i_type(12'd7, 1, 3'd0, 0, 7'h13));         // addi x0, x1, 7
		prog.push_back(s_type(12'd56, 0, 0));
		prog.push_back(u_type(20'h12345, 19, 7'h37));             // lui x19, 0x12345
		prog.push_back(u_type(20'h00001, 20, 7'h17));             // 0x8c auipc x20, 1
		prog.push_back(s_type(12'd60, 19, 0));
		prog.push_back(s_type(12'd64, 20, 0));
		push_branch_pair(3'd0, 1, 2, 1, 1);     // beq
		push_branch_pair(3'd1, 1, 1, 1, 2);     // bne
		push_branch_pair(3'd4, 1, 10, 10, 1);   // blt where 12 < -16 is false
		push_branch_pair(3'd5, 10, 1, 1, 10);   // bge
		push_branch_pair(3'd6, 10, 1, 1, 10);   // bltu sees 0xfffffff0 as large
		push_branch_pair(3'd7, 1, 10, 10, 1);   // bgeu
		prog.push_back(s_type(12'd68, 2, 0));                     // All branches passed
		prog.push_back(j_type(21'd12, 21));                       // 0xfc jal x21, +12
		prog.push_back(poison_store());
		prog.push_back(poison_store());
		prog.push_back(s_type(12'd72, 21, 0));                    // 0x108 JAL target
		prog.push_back(i_type(12'd285, 0, 3'd0, 22, 7'h13));      // Odd x22 = 0x11d
		prog.push_back(i_type(12'd0, 22, 3'd0, 23, 7'h67));       // 0x110 jalr x23, 0(x22)
		prog.push_back(poison_store());
		prog.push_back(poison_store());
		prog.push_back(s_type(12'd76, 23, 0));                    // 0x11c JALR target
	endtask

	task automatic expect_store(string name, rv_pkg::word_t addr, rv_pkg::word_t data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// Values from RV32I semantics with registers starting at zero
	task automatic load_expected();
		expect_store("add", 32'h00, 32'd17);
		expect_store("sub", 32'h04, 32'd7);
		expect_store("xor", 32'h08, 32'd9);
		expect_store("or", 32'h0c, 32'd13);
		expect_store("and", 32'h10, 32'd4);
		expect_store("slt", 32'h14, 32'd1);
		expect_store("sltu", 32'h18, 32'd0);
		expect_store("addi_negative", 32'h1c, 32'hffff_fff0);
		expect_store("slli", 32'h20, 32'hffff_ff00);
		expect_store("srli", 32'h24, 32'h0fff_ffff);
		expect_store("srai", 32'h28, 32'hffff_fffc);
		expect_store("slti", 32'h2c, 32'd1);
		expect_store("sltiu", 32'h30, 32'd1);
		expect_store("forward_chain", 32'h34, 32'd21);
		expect_store("x0_write", 32'h38, 32'd0);
		expect_store("lui", 32'h3c, 32'h1234_5000);
		expect_store("auipc", 32'h40, 32'h0000_108c);
		expect_store("branches", 32'h44, 32'd5);
		expect_store("jal_link", 32'h48, 32'h0000_0100);
		expect_store("jalr_link", 32'h4c, 32'h0000_0114);
	endtask

	task automatic check_value(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Instruction memory answers one cycle after the address
	always @(posedge clk) begin
		imem_rddata <= rom_word(imem_addr);
	end

	initial begin
		int timeout_cycles;
		wait (tables_ready);
		timeout_cycles = 4 * prog.size() + 100;
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, only %0d of %0d expected stores arrived",
			timeout_cycles, stores_seen, exp_addr.size());
		$display("Simulation FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		load_program();
		load_expected();
		tables_ready = 1'b1;
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_value("imem_rd_in_reset", 32'd0, {31'd0, imem_rd});
		@(posedge clk);
		reset <= 1'b0;

		for (int n = 0; n < exp_addr.size(); n++) begin
			do begin
				@(negedge clk);
				check_value("imem_rd", 32'd1, {31'd0, imem_rd});
			end while (!st_wr);
			check_value({exp_name[n], " address"}, exp_addr[n], st_addr);
			check_value({exp_name[n], " data"}, exp_data[n], st_data);
			stores_seen = n + 1;
		end

		// Squashed slots must stay silent
		repeat (20) begin
			@(negedge clk);
			check_value("no_extra_store", 32'd0, {31'd0, st_wr});
			check_value("imem_rd", 32'd1, {31'd0, imem_rd});
		end
		$display("Simulation PASSED");
		$finish;
	end
endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD_NS = 5  // 10 ns period
)(
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end
endmodule
